// File: all.f
+incdir+rtl
rtl/core_pkg.sv
rtl/inst_fetch.sv
rtl/cycle_fsm.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/data_mem.sv
rtl/multicycle_core.sv
tests/clk_gen.sv
tests/core_chk.sv
tests/core_monitor.sv
tests/core_tb.sv

// File: rtl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath and storage sizes
`define XLEN        32
`define REG_ADDR_W  5
`define IMEM_DEPTH  8
`define DMEM_DEPTH  8
`define DMEM_ADDR_W 3
`define PROG_W      256

// supported opcodes
`define OP_R        7'b0110011
`define OP_IMM      7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011

`define F3_ADD      3'b000
`define F3_LW       3'b010
`define F7_ADD      7'b0000000
`define F7_SUB      7'b0100000

// number of instructions executed before the core stops
`define HALT_COUNT  8

// data store contents after reset, 45 and -20
`define DMEM_INIT0  32'd45
`define DMEM_INIT1  32'hFFFF_FFEC

`endif

// File: rtl/core_pkg.sv
`default_nettype none
`include "core_consts.svh"

package core_pkg;

    // register form, used by add and sub
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_form_t;

    // immediate form, shared by addi and lw
    typedef struct packed {
        logic [11:0]            imm12;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_form_t;

    // store form with the split immediate
    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        logic [6:0]             opcode;
    } s_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
        s_form_t s_form;
    } inst_t;

    // one-hot class, all zero for an invalid word
    typedef enum logic [3:0] {
        CLS_NONE = 4'b0000,
        CLS_R    = 4'b1000,
        CLS_I    = 4'b0100,
        CLS_S    = 4'b0010,
        CLS_L    = 4'b0001
    } inst_class_e;

    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_op_e;

    typedef enum logic [1:0] {
        PH_FETCH  = 2'd0,
        PH_DECODE = 2'd1,
        PH_EXEC   = 2'd2,
        PH_WB     = 2'd3
    } phase_e;

endpackage

`default_nettype wire

// File: rtl/cycle_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_fsm
    import core_pkg::*;
(
    input  wire    clk,
    input  wire    rst,
    input  wire    i_done,
    output phase_e o_phase
);

    phase_e next_phase;

    always_comb
    begin
        next_phase = o_phase;
        case (o_phase)
            PH_FETCH:
            begin
                // parked here once the program has finished
                if (!i_done)
                begin
                    next_phase = PH_DECODE;
                end
            end
            PH_DECODE:
            begin
                next_phase = PH_EXEC;
            end
            PH_EXEC:
            begin
                next_phase = PH_WB;
            end
            PH_WB:
            begin
                next_phase = PH_FETCH;
            end
            default:
            begin
                next_phase = PH_FETCH;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_phase <= PH_FETCH;
        end
        else
        begin
            o_phase <= next_phase;
        end
    end

endmodule

`default_nettype wire

// File: rtl/data_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module data_mem
    import core_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire  phase_e            i_phase,
    input  wire  [`DMEM_ADDR_W-1:0] i_addr,
    input  wire                     i_we,
    input  wire  [`XLEN-1:0]        i_wdata,
    output logic [`XLEN-1:0]        o_rdata
);

    logic [`XLEN-1:0] mem [`DMEM_DEPTH];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `DMEM_DEPTH; i++)
            begin
                mem[i] <= (i == 0) ? `DMEM_INIT0 : (i == 1) ? `DMEM_INIT1 : '0;
            end
        end
        else if (i_phase == PH_WB && i_we)
        begin
            mem[i_addr] <= i_wdata;
        end
    end

    // address is the registered exec result, so the word is valid from the end of EXEC
    assign o_rdata = mem[i_addr];

endmodule

`default_nettype wire

// File: rtl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module exec_unit
    import core_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire  phase_e       i_phase,
    input  wire  inst_class_e  i_class,
    input  wire  alu_op_e      i_alu_op,
    input  wire  [`XLEN-1:0]   i_a,
    input  wire  [`XLEN-1:0]   i_b,
    input  wire  [`XLEN-1:0]   i_imm,
    output logic [`XLEN-1:0]   o_result
);

    logic             use_rs2;
    logic             do_sub;
    logic [`XLEN-1:0] operand_b;
    logic [`XLEN-1:0] sum;

    // only the register class takes rs2, the rest add the immediate
    assign use_rs2   = (i_class == CLS_R);
    assign do_sub    = use_rs2 && (i_alu_op == ALU_SUB);
    assign operand_b = use_rs2 ? i_b : i_imm;

    // plain adder/subtractor, wraps at 32 bits
    assign sum = do_sub ? (i_a - operand_b) : (i_a + operand_b);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_result <= '0;
        end
        else if (i_phase == PH_EXEC)
        begin
            o_result <= (i_class == CLS_NONE) ? '0 : sum;
        end
    end

endmodule

`default_nettype wire

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module inst_decoder
    import core_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire  phase_e              i_phase,
    input  wire  inst_t               i_word,
    output logic [`REG_ADDR_W-1:0]    o_rs1,
    output logic [`REG_ADDR_W-1:0]    o_rs2,
    output logic [`REG_ADDR_W-1:0]    o_rd,
    output logic [`XLEN-1:0]          o_imm,
    output inst_class_e               o_class,
    output alu_op_e                   o_alu_op
);

    logic [`REG_ADDR_W-1:0] dec_rs1;
    logic [`REG_ADDR_W-1:0] dec_rs2;
    logic [`REG_ADDR_W-1:0] dec_rd;
    logic [11:0]            dec_imm12;
    inst_class_e            dec_class;
    alu_op_e                dec_op;

    always_comb
    begin
        dec_rs1   = '0;
        dec_rs2   = '0;
        dec_rd    = '0;
        dec_imm12 = '0;
        dec_class = CLS_NONE;
        dec_op    = ALU_ADD;
        case (i_word.r_form.opcode)
            `OP_R:
            begin
                if (i_word.r_form.funct3 == `F3_ADD &&
                    (i_word.r_form.funct7 == `F7_ADD || i_word.r_form.funct7 == `F7_SUB))
                begin
                    dec_class = CLS_R;
                    dec_rs1   = i_word.r_form.rs1;
                    dec_rs2   = i_word.r_form.rs2;
                    dec_rd    = i_word.r_form.rd;
                    dec_op    = (i_word.r_form.funct7 == `F7_SUB) ? ALU_SUB : ALU_ADD;
                end
            end
            `OP_IMM, `OP_LOAD:
            begin
                // addi and lw share the immediate layout
                if ((i_word.i_form.opcode == `OP_IMM && i_word.i_form.funct3 == `F3_ADD) ||
                    (i_word.i_form.opcode == `OP_LOAD && i_word.i_form.funct3 == `F3_LW))
                begin
                    dec_class = (i_word.i_form.opcode == `OP_IMM) ? CLS_I : CLS_L;
                    dec_rs1   = i_word.i_form.rs1;
                    dec_rd    = i_word.i_form.rd;
                    dec_imm12 = i_word.i_form.imm12;
                end
            end
            `OP_STORE:
            begin
                // any funct3 is taken as a word store
                dec_class = CLS_S;
                dec_rs1   = i_word.s_form.rs1;
                dec_rs2   = i_word.s_form.rs2;
                dec_imm12 = {i_word.s_form.imm_hi, i_word.s_form.imm_lo};
            end
            default:
            begin
            end
        endcase
    end

    // register indices go straight to the register file read ports
    assign o_rs1 = dec_rs1;
    assign o_rs2 = dec_rs2;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_rd     <= '0;
            o_imm    <= '0;
            o_class  <= CLS_NONE;
            o_alu_op <= ALU_ADD;
        end
        else if (i_phase == PH_DECODE)
        begin
            o_rd     <= dec_rd;
            o_imm    <= {{(`XLEN-12){dec_imm12[11]}}, dec_imm12};
            o_class  <= dec_class;
            o_alu_op <= dec_op;
        end
    end

endmodule

`default_nettype wire

// File: rtl/inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module inst_fetch
    import core_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire  [`PROG_W-1:0] i_program,
    input  wire  phase_e       i_phase,
    output inst_t              o_word,
    output logic               o_done
);

    localparam int PC_W  = $clog2(`IMEM_DEPTH + 1);
    localparam int IDX_W = $clog2(`IMEM_DEPTH);

    logic [`XLEN-1:0] imem [`IMEM_DEPTH];
    logic [PC_W-1:0]  pc;

    // program image is captured on every reset cycle, word 0 from the low bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `IMEM_DEPTH; i++)
            begin
                imem[i] <= i_program[i*`XLEN +: `XLEN];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc     <= '0;
            o_word <= '0;
            o_done <= 1'b0;
        end
        else
        begin
            if (i_phase == PH_FETCH && !o_done)
            begin
                o_word <= imem[pc[IDX_W-1:0]];
                pc     <= pc + 1'b1;
            end
            // last word fetched and its write-back just ended
            if (i_phase == PH_WB && pc == PC_W'(`HALT_COUNT))
            begin
                o_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/multicycle_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module multicycle_core
    import core_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire  [`PROG_W-1:0]       i_instruction,
    output logic [`XLEN-1:0]         o_current_instruction,
    output logic [`XLEN-1:0]         o_read_val1,
    output logic [`XLEN-1:0]         o_read_val2,
    output logic [`XLEN-1:0]         o_imm,
    output logic [`XLEN-1:0]         o_alu_result,
    output logic [`XLEN-1:0]         o_wb_data,
    output logic [`XLEN-1:0]         o_st_data,
    output inst_class_e              o_inst_class,
    output logic                     o_wb_en,
    output logic [`REG_ADDR_W-1:0]   o_wb_addr,
    output logic                     o_st_en,
    output logic [`DMEM_ADDR_W-1:0]  o_st_addr,
    output logic                     o_done
);

    phase_e                 phase;
    inst_t                  word;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm;
    inst_class_e            cls;
    alu_op_e                alu_op;
    logic [`XLEN-1:0]       rdata1;
    logic [`XLEN-1:0]       rdata2;
    logic [`XLEN-1:0]       result;
    logic [`XLEN-1:0]       load_data;
    logic                   wb_en;
    logic                   st_en;

    inst_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .i_program (i_instruction),
        .i_phase   (phase),
        .o_word    (word),
        .o_done    (o_done)
    );

    cycle_fsm u_fsm (
        .clk     (clk),
        .rst     (rst),
        .i_done  (o_done),
        .o_phase (phase)
    );

    inst_decoder u_decoder (
        .clk      (clk),
        .rst      (rst),
        .i_phase  (phase),
        .i_word   (word),
        .o_rs1    (rs1),
        .o_rs2    (rs2),
        .o_rd     (rd),
        .o_imm    (imm),
        .o_class  (cls),
        .o_alu_op (alu_op)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .i_phase  (phase),
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .i_rd     (rd),
        .i_we     (wb_en),
        .i_wdata  (o_wb_data),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    exec_unit u_exec (
        .clk      (clk),
        .rst      (rst),
        .i_phase  (phase),
        .i_class  (cls),
        .i_alu_op (alu_op),
        .i_a      (rdata1),
        .i_b      (rdata2),
        .i_imm    (imm),
        .o_result (result)
    );

    // store address wraps modulo the data store depth
    data_mem u_dmem (
        .clk     (clk),
        .rst     (rst),
        .i_phase (phase),
        .i_addr  (result[`DMEM_ADDR_W-1:0]),
        .i_we    (st_en),
        .i_wdata (rdata2),
        .o_rdata (load_data)
    );

    // register write for R, I and L, never to x0
    assign wb_en = (phase == PH_WB) && (rd != '0) &&
                   (cls == CLS_R || cls == CLS_I || cls == CLS_L);
    assign st_en = (phase == PH_WB) && (cls == CLS_S);

    assign o_wb_data = (cls == CLS_L) ? load_data : result;
    assign o_wb_en   = wb_en;
    assign o_wb_addr = rd;
    assign o_st_en   = st_en;
    assign o_st_addr = result[`DMEM_ADDR_W-1:0];
    assign o_st_data = rdata2;

    // observation outputs
    assign o_current_instruction = word;
    assign o_read_val1           = rdata1;
    assign o_read_val2           = rdata2;
    assign o_imm                 = imm;
    assign o_inst_class          = cls;
    assign o_alu_result          = result;

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module reg_file
    import core_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire  phase_e              i_phase,
    input  wire  [`REG_ADDR_W-1:0]    i_rs1,
    input  wire  [`REG_ADDR_W-1:0]    i_rs2,
    input  wire  [`REG_ADDR_W-1:0]    i_rd,
    input  wire                       i_we,
    input  wire  [`XLEN-1:0]          i_wdata,
    output logic [`XLEN-1:0]          o_rdata1,
    output logic [`XLEN-1:0]          o_rdata2
);

    localparam int NREGS = 1 << `REG_ADDR_W;

    logic [`XLEN-1:0] regs [NREGS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NREGS; i++)
            begin
                regs[i] <= '0;
            end
            o_rdata1 <= '0;
            o_rdata2 <= '0;
        end
        else
        begin
            if (i_phase == PH_DECODE)
            begin
                o_rdata1 <= (i_rs1 == '0) ? '0 : regs[i_rs1];
                o_rdata2 <= (i_rs2 == '0) ? '0 : regs[i_rs2];
            end
            // x0 is never written
            if (i_phase == PH_WB && i_we && i_rd != '0)
            begin
                regs[i_rd] <= i_wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen
(
    output logic o_clk
);

    // 10 ns period, first rising edge at 5 ns
    initial
    begin
        o_clk = 1'b0;
    end

    always #5 o_clk = ~o_clk;

endmodule

`default_nettype wire

// File: tests/core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module core_chk
(
    input wire clk,
    input wire rst,
    input wire i_wb_en,
    input wire i_st_en,
    input wire i_done
);

    int fail_count = 0;

    // register write and store never share a WB cycle
    strobes_exclusive: assert property (@(posedge clk) disable iff (rst) !(i_wb_en && i_st_en))
    else
    begin
        $error("o_wb_en and o_st_en high in the same cycle");
        fail_count++;
    end

    wb_single_cycle: assert property (@(posedge clk) disable iff (rst) i_wb_en |=> !i_wb_en)
    else
    begin
        $error("o_wb_en high for more than one cycle");
        fail_count++;
    end

    st_single_cycle: assert property (@(posedge clk) disable iff (rst) i_st_en |=> !i_st_en)
    else
    begin
        $error("o_st_en high for more than one cycle");
        fail_count++;
    end

    // only reset clears done
    done_sticky: assert property (@(posedge clk) (i_done && !rst) |=> i_done)
    else
    begin
        $error("o_done fell without reset");
        fail_count++;
    end

endmodule

bind multicycle_core core_chk u_chk (
    .clk     (clk),
    .rst     (rst),
    .i_wb_en (o_wb_en),
    .i_st_en (o_st_en),
    .i_done  (o_done)
);

`default_nettype wire

// File: tests/core_monitor.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_monitor
    import core_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`PROG_W-1:0]       i_program,
    input  wire [`XLEN-1:0]         i_current_instruction,
    input  wire [`XLEN-1:0]         i_read_val1,
    input  wire [`XLEN-1:0]         i_read_val2,
    input  wire [`XLEN-1:0]         i_imm,
    input  wire [`XLEN-1:0]         i_alu_result,
    input  wire [`XLEN-1:0]         i_wb_data,
    input  wire [`XLEN-1:0]         i_st_data,
    input  wire [3:0]               i_inst_class,
    input  wire                     i_wb_en,
    input  wire [`REG_ADDR_W-1:0]   i_wb_addr,
    input  wire                     i_st_en,
    input  wire [`DMEM_ADDR_W-1:0]  i_st_addr,
    input  wire                     i_done,
    output int                      o_tests_passed,
    output int                      o_tests_failed,
    output int                      o_errors
);

    localparam int LAST_CYCLE = 4 * `HALT_COUNT;

    logic [31:0] m_regs [32];
    logic [31:0] m_mem  [8];
    logic [3:0]  m_cls;
    logic [4:0]  m_rs1;
    logic [4:0]  m_rs2;
    logic [4:0]  m_rd;
    logic [31:0] m_imm;
    logic        m_sub;
    logic [31:0] m_a;
    logic [31:0] m_b;
    logic [31:0] m_res;
    int          cyc;
    int          test_num;
    int          test_errs;

    initial
    begin
        cyc            = 0;
        test_num       = 0;
        test_errs      = 0;
        o_tests_passed = 0;
        o_tests_failed = 0;
        o_errors       = 0;
    end

    // cycle count after reset, cycle 1 is the first fetch
    always @(posedge clk)
    begin
        if (rst)
        begin
            if (cyc != 0)
            begin
                test_num <= test_num + 1;
            end
            cyc <= 0;
        end
        else
        begin
            cyc <= cyc + 1;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            test_errs++;
            o_errors++;
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < 32; i++)
        begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 8; i++)
        begin
            m_mem[i] = '0;
        end
        m_mem[0]  = 32'd45;
        m_mem[1]  = -32'sd20;
        test_errs = 0;
    endtask

    task automatic decode_word(input logic [31:0] w);
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        op    = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        m_cls = CLS_NONE;
        m_rs1 = '0;
        m_rs2 = '0;
        m_rd  = '0;
        m_imm = '0;
        m_sub = 1'b0;
        if (op == `OP_R && f3 == 3'b000 && (f7 == 7'b0000000 || f7 == 7'b0100000))
        begin
            m_cls = CLS_R;
            {m_rs2, m_rs1, m_rd} = {w[24:20], w[19:15], w[11:7]};
            m_sub = f7[5];
        end
        else if ((op == `OP_IMM && f3 == 3'b000) || (op == `OP_LOAD && f3 == 3'b010))
        begin
            m_cls = (op == `OP_IMM) ? CLS_I : CLS_L;
            {m_rs1, m_rd} = {w[19:15], w[11:7]};
            m_imm = {{20{w[31]}}, w[31:20]};
        end
        else if (op == `OP_STORE)
        begin
            m_cls = CLS_S;
            {m_rs2, m_rs1} = {w[24:20], w[19:15]};
            m_imm = {{20{w[31]}}, w[31:25], w[11:7]};
        end
    endtask

    task automatic check_idle();
        check_val("o_wb_en", 1'b0, i_wb_en);
        check_val("o_st_en", 1'b0, i_st_en);
    endtask

    // strobes are combinational on the WB phase, so they show right after EXEC
    task automatic check_exec_wb();
        logic        exp_wb;
        logic [31:0] wdata;
        if (m_cls == CLS_NONE)
        begin
            m_res = '0;
        end
        else if (m_cls == CLS_R)
        begin
            m_res = m_sub ? (m_a - m_b) : (m_a + m_b);
        end
        else
        begin
            m_res = m_a + m_imm;
        end
        check_val("o_alu_result", m_res, i_alu_result);
        exp_wb = (m_cls == CLS_R || m_cls == CLS_I || m_cls == CLS_L) && m_rd != 0;
        check_val("o_wb_en", exp_wb, i_wb_en);
        check_val("o_st_en", m_cls == CLS_S, i_st_en);
        if (exp_wb)
        begin
            wdata = (m_cls == CLS_L) ? m_mem[m_res % 8] : m_res;
            check_val("o_wb_addr", m_rd, i_wb_addr);
            check_val("o_wb_data", wdata, i_wb_data);
            m_regs[m_rd] = wdata;
        end
        if (m_cls == CLS_S)
        begin
            check_val("o_st_addr", m_res % 8, i_st_addr);
            check_val("o_st_data", m_b, i_st_data);
            m_mem[m_res % 8] = m_b;
        end
    endtask

    always @(negedge clk)
    begin
        int k;
        if (cyc == 0)
        begin
            reset_model();
        end
        else
        begin
            k = (cyc - 1) / 4;
            if (cyc > LAST_CYCLE)
            begin
                check_idle();
            end
            else
            begin
                case ((cyc - 1) % 4)
                    0:
                    begin
                        decode_word(i_program[k*32 +: 32]);
                        check_val("o_current_instruction", i_program[k*32 +: 32],
                                  i_current_instruction);
                        check_idle();
                    end
                    1:
                    begin
                        // x0 is never written in the model
                        m_a = m_regs[m_rs1];
                        m_b = m_regs[m_rs2];
                        check_val("o_inst_class", m_cls, i_inst_class);
                        check_val("o_imm", m_imm, i_imm);
                        check_val("o_read_val1", m_a, i_read_val1);
                        check_val("o_read_val2", m_b, i_read_val2);
                        check_idle();
                    end
                    2: check_exec_wb();
                    default: check_idle();
                endcase
            end
            check_val("o_done", cyc >= LAST_CYCLE, i_done);
            if (cyc == LAST_CYCLE)
            begin
                if (test_errs == 0)
                begin
                    $display("test %0d: passed", test_num);
                    o_tests_passed++;
                end
                else
                begin
                    $display("test %0d: failed with %0d mismatches", test_num, test_errs);
                    o_tests_failed++;
                end
            end
        end
    end

    task automatic report_totals(input int timeouts, input int assert_fails);
        $display("totals: %0d passed, %0d failed, %0d timeouts, %0d mismatches, %0d assert fails",
                 o_tests_passed, o_tests_failed, timeouts, o_errors, assert_fails);
    endtask

endmodule

`default_nettype wire

// File: tests/core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_tb;

    localparam int          NUM_TESTS    = 20;
    localparam int          DONE_TIMEOUT = 40;
    localparam logic [31:0] LFSR_SEED    = 32'he1c8_c763;

    logic                    clk;
    logic                    rst;
    logic [`PROG_W-1:0]      prog_image;
    logic [`XLEN-1:0]        current_instruction;
    logic [`XLEN-1:0]        read_val1;
    logic [`XLEN-1:0]        read_val2;
    logic [`XLEN-1:0]        imm;
    logic [`XLEN-1:0]        alu_result;
    logic [`XLEN-1:0]        wb_data;
    logic [`XLEN-1:0]        st_data;
    logic [3:0]              inst_class;
    logic                    wb_en;
    logic [`REG_ADDR_W-1:0]  wb_addr;
    logic                    st_en;
    logic [`DMEM_ADDR_W-1:0] st_addr;
    logic                    done;
    int                      tests_passed;
    int                      tests_failed;
    int                      mismatches;
    int                      timeouts;
    logic [31:0]             lfsr;

    clk_gen clk_gen_i (
        .o_clk (clk)
    );

    multicycle_core multicycle_core_i (
        .clk                   (clk),
        .rst                   (rst),
        .i_instruction         (prog_image),
        .o_current_instruction (current_instruction),
        .o_read_val1           (read_val1),
        .o_read_val2           (read_val2),
        .o_imm                 (imm),
        .o_alu_result          (alu_result),
        .o_wb_data             (wb_data),
        .o_st_data             (st_data),
        .o_inst_class          (inst_class),
        .o_wb_en               (wb_en),
        .o_wb_addr             (wb_addr),
        .o_st_en               (st_en),
        .o_st_addr             (st_addr),
        .o_done                (done)
    );

    core_monitor mon_i (
        .clk                   (clk),
        .rst                   (rst),
        .i_program             (prog_image),
        .i_current_instruction (current_instruction),
        .i_read_val1           (read_val1),
        .i_read_val2           (read_val2),
        .i_imm                 (imm),
        .i_alu_result          (alu_result),
        .i_wb_data             (wb_data),
        .i_st_data             (st_data),
        .i_inst_class          (inst_class),
        .i_wb_en               (wb_en),
        .i_wb_addr             (wb_addr),
        .i_st_en               (st_en),
        .i_st_addr             (st_addr),
        .i_done                (done),
        .o_tests_passed        (tests_passed),
        .o_tests_failed        (tests_failed),
        .o_errors              (mismatches)
    );

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // eight random words over x0..x7, immediates -8..15
    task automatic make_program(output logic [`PROG_W-1:0] image);
        logic [31:0] sel;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] iv;
        logic [31:0] kind;
        logic [31:0] iimm;
        logic [31:0] word;
        image = '0;
        for (int i = 0; i < `IMEM_DEPTH; i++)
        begin
            take_bits(3, sel);
            take_bits(3, rd);
            take_bits(3, rs1);
            take_bits(3, rs2);
            take_bits(5, iv);
            iimm = (iv % 24) - 32'd8;
            case (sel)
                0, 1: word = {iimm[11:0], 2'b00, rs1[2:0], 3'b000, 2'b00, rd[2:0], `OP_IMM};
                2: word = {7'b0000000, 2'b00, rs2[2:0], 2'b00, rs1[2:0], 3'b000,
                           2'b00, rd[2:0], `OP_R};
                3: word = {7'b0100000, 2'b00, rs2[2:0], 2'b00, rs1[2:0], 3'b000,
                           2'b00, rd[2:0], `OP_R};
                4: word = {iimm[11:0], 2'b00, rs1[2:0], 3'b010, 2'b00, rd[2:0], `OP_LOAD};
                5, 6: word = {iimm[11:5], 2'b00, rs2[2:0], 2'b00, rs1[2:0], 3'b010,
                              iimm[4:0], `OP_STORE};
                default:
                begin
                    // xori, lb, jalr and mul all decode as no-ops
                    take_bits(2, kind);
                    case (kind)
                        0: word = {iimm[11:0], 2'b00, rs1[2:0], 3'b100, 2'b00, rd[2:0],
                                   `OP_IMM};
                        1: word = {iimm[11:0], 2'b00, rs1[2:0], 3'b000, 2'b00, rd[2:0],
                                   `OP_LOAD};
                        2: word = {iimm[11:0], 2'b00, rs1[2:0], 3'b000, 2'b00, rd[2:0],
                                   7'b1100111};
                        default: word = {7'b0000001, 2'b00, rs2[2:0], 2'b00, rs1[2:0],
                                         3'b000, 2'b00, rd[2:0], `OP_R};
                    endcase
                end
            endcase
            image[i*`XLEN +: `XLEN] = word;
        end
    endtask

    task automatic wait_for_done(output logic seen);
        seen = 1'b0;
        for (int n = 0; n < DONE_TIMEOUT && !seen; n++)
        begin
            @(negedge clk);
            seen = (done === 1'b1);
        end
    endtask

    initial
    begin
        logic [`PROG_W-1:0] image;
        logic               seen;
        rst        = 1'b1;
        prog_image = '0;
        lfsr       = LFSR_SEED;
        timeouts   = 0;
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            make_program(image);
            @(negedge clk);
            rst        = 1'b1;
            prog_image = image;
            // three rising edges with reset high
            repeat (3) @(negedge clk);
            rst = 1'b0;
            wait_for_done(seen);
            if (!seen)
            begin
                $display("test %0d: o_done did not rise within %0d cycles after reset",
                         t, DONE_TIMEOUT);
                timeouts++;
            end
        end
        // monitor has finished its falling-edge checks by the next rising edge
        @(posedge clk);
        mon_i.report_totals(timeouts, multicycle_core_i.u_chk.fail_count);
        if (timeouts == 0 && tests_failed == 0 && mismatches == 0 &&
            tests_passed == NUM_TESTS && multicycle_core_i.u_chk.fail_count == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
